// ==== sources.f ====
+incdir+include
source/sg_pkg.sv
source/sg_cmd_regs.sv
source/sg_reader.sv
source/sg_fifo.sv
source/sg_dma_top.sv
bench/sg_wb_mem.sv
bench/tb_sg_dma.sv

// ==== Makefile ====
TOP = tb_sg_dma

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== bench/tb_sg_dma.sv ====
`timescale 1ns/10ps
`include "sg_defines.svh"

module tb_sg_dma
   import sg_pkg::*;
();

   localparam int    WORDS = 41;                         // buffer words of all tests
   localparam longint LIMIT = (WORDS * 200 + 1000) * 100;   // ns

   logic        wb_clk_i;
   logic        wb_rst_i;
   logic        reg_we;
   sg_reg_e     reg_adr;
   logic [31:0] reg_dat;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   sg_word_t    dat;
   logic        valid;
   logic        pop;
   sg_status_t  status;
   logic [2:0]  dly_mask;
   logic        rty_en;
   logic        err_en;
   logic [31:0] err_adr;
   sg_word_t    exp_q[$];   // buffers in chain order
   int          errors;
   int          checks;
   int          err_mark;   // errors before the current test

   sg_dma_top i_sg_dma_top (
      .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i), .reg_we_i (reg_we),
      .reg_adr_i (reg_adr), .reg_dat_i (reg_dat), .wb_req_o (wb_req),
      .wb_rsp_i (wb_rsp), .dat_o (dat), .valid_o (valid), .pop_i (pop),
      .status_o (status)
   );

   sg_wb_mem i_sg_wb_mem (
      .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i), .wb_req_i (wb_req),
      .wb_rsp_o (wb_rsp), .dly_mask_i (dly_mask), .rty_en_i (rty_en),
      .err_en_i (err_en), .err_adr_i (err_adr)
   );

   always #50 wb_clk_i = ~wb_clk_i;   // 100 ns period

   function automatic sg_word_t fill_word(input logic [31:0] a);
      return {a ^ 32'h5a3c_96e1, ~a};   // whole address in both halves
   endfunction

   task automatic check_val(input string name, input sg_word_t exp, input sg_word_t got);
      checks++;
      assert (got == exp) else begin
         $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic report(input string name);
      if (errors == err_mark) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   task automatic reg_write(input sg_reg_e adr, input logic [31:0] val);
      @(posedge wb_clk_i);
      #1;
      reg_we  = 1'b1;
      reg_adr = adr;
      reg_dat = val;
      @(posedge wb_clk_i);
      #1;
      reg_we = 1'b0;
   endtask

   // descriptor at ptr plus its buffer; expected words queued in order
   task automatic build_desc(input logic [31:0] ptr, input logic [31:0] buf_adr,
                             input int len, input logic last, input logic [31:0] next);
      logic [31:0] hi;
      logic [31:0] a;
      hi                   = '0;
      hi[`SG_LEN_W-1:0]    = len[`SG_LEN_W-1:0];
      hi[`SG_LAST_BIT]     = last;
      i_sg_wb_mem.mem[ptr[14:3]]         = {hi, buf_adr};
      i_sg_wb_mem.mem[ptr[14:3] + 12'd1] = {next, 32'h0};   // next pointer in high word
      for (int i = 0; i < len; i++) begin
         a = buf_adr + 32'(i * 8);
         i_sg_wb_mem.mem[a[14:3]] = fill_word(a);
         exp_q.push_back(fill_word(a));
      end
   endtask

   task automatic start_run(input logic [31:0] ptr);
      reg_write(REG_NEXT, ptr);
      reg_write(REG_GO, 32'd0);
   endtask

   // pop n words, at most one per `every` cycles
   task automatic consume(input int n, input int every);
      int got;
      int tick;
      got  = 0;
      tick = 0;
      while (got < n) begin
         @(posedge wb_clk_i);
         #1;
         pop = 1'b0;
         tick++;
         if (valid && tick >= every) begin
            tick = 0;
            check_val("dat_o", exp_q.pop_front(), dat);
            pop = 1'b1;
            got++;
         end
      end
      @(posedge wb_clk_i);
      #1;
      pop = 1'b0;
   endtask

   // no pops until the fifo is full, then the bus must stay quiet
   task automatic hold_full(input int cycles);
      while (i_sg_dma_top.fifo_ready) begin
         @(posedge wb_clk_i);
         #1;
      end
      repeat (cycles) begin
         check_val("wb_req_o.stb", 64'(0), 64'(wb_req.stb));
         @(posedge wb_clk_i);
         #1;
      end
   endtask

   task automatic wait_state(input sg_state_e s);
      while (status.state != s) begin
         @(posedge wb_clk_i);
         #1;
      end
   endtask

   task automatic clear_run();
      reg_write(REG_CLEAR, 32'd0);
      @(posedge wb_clk_i);   // clear pulse, then idle
      #1;
      check_val("status_o.state", 64'(S_IDLE), 64'(status.state));
   endtask

   task automatic test_reset();
      check_val("wb_req_o.cyc", 64'(0), 64'(wb_req.cyc));
      check_val("valid_o", 64'(0), 64'(valid));
      check_val("status_o.state", 64'(S_IDLE), 64'(status.state));
      report("reset");
   endtask

   task automatic test_single();
      build_desc(32'h100, 32'h1000, 5, 1'b1, 32'h0);
      start_run(32'h100);
      consume(5, 1);
      wait_state(S_END);
      check_val("valid_o", 64'(0), 64'(valid));   // nothing beyond five words
      clear_run();
      report("single");
   endtask

   task automatic test_chain();
      build_desc(32'h200, 32'h2000, 1, 1'b0, 32'h300);
      build_desc(32'h300, 32'h2400, 4, 1'b0, 32'h400);
      build_desc(32'h400, 32'h2800, 9, 1'b1, 32'h0);
      start_run(32'h200);
      consume(14, 1);
      wait_state(S_END);
      check_val("status_o.desc.last", 64'(1), 64'(status.desc.last));
      check_val("valid_o", 64'(0), 64'(valid));
      clear_run();
      report("chain");
   endtask

   task automatic test_backpressure();
      dly_mask = 3'd7;
      rty_en   = 1'b1;
      build_desc(32'h500, 32'h1800, 6, 1'b0, 32'h600);
      build_desc(32'h600, 32'h1c00, 8, 1'b1, 32'h0);
      start_run(32'h500);
      hold_full(10);    // fifo fills, requests must stall
      consume(14, 5);
      wait_state(S_END);
      check_val("valid_o", 64'(0), 64'(valid));
      clear_run();
      dly_mask = 3'd3;
      rty_en   = 1'b0;
      report("backpressure");
   endtask

   task automatic test_error();
      err_adr = 32'h780;   // second descriptor answers with err
      err_en  = 1'b1;
      build_desc(32'h700, 32'h3000, 3, 1'b0, 32'h780);
      start_run(32'h700);
      consume(3, 1);
      wait_state(S_PANIC);
      check_val("status_o.err_state", 64'(S_D_REQ), 64'(status.err_state));
      check_val("wb_req_o.cyc", 64'(0), 64'(wb_req.cyc));
      check_val("valid_o", 64'(0), 64'(valid));
      clear_run();
      err_en = 1'b0;
      build_desc(32'h100, 32'h1000, 5, 1'b1, 32'h0);   // good run after recovery
      start_run(32'h100);
      consume(5, 1);
      wait_state(S_END);
      clear_run();
      report("error");
   endtask

   initial begin
      #(LIMIT);
      $display("watchdog expired before the tests finished");
      $display("Test failed");
      $finish;
   end

   initial begin
      wb_clk_i = 1'b0;
      wb_rst_i = 1'b1;
      reg_we   = 1'b0;
      reg_adr  = REG_RSVD;
      reg_dat  = 32'd0;
      pop      = 1'b0;
      dly_mask = 3'd3;
      rty_en   = 1'b0;
      err_en   = 1'b0;
      err_adr  = 32'd0;
      errors   = 0;
      checks   = 0;
      err_mark = 0;
      repeat (2) @(posedge wb_clk_i);
      #1;
      wb_rst_i = 1'b0;
      test_reset();
      test_single();
      test_chain();
      test_backpressure();
      test_error();
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== bench/sg_wb_mem.sv ====
`timescale 1ns/10ps

module sg_wb_mem
   import sg_pkg::*;
(
   input  logic        wb_clk_i,     // bus clock
   input  logic        wb_rst_i,     // async reset, active high
   input  wb_req_t     wb_req_i,     // read request from the engine
   output wb_rsp_t     wb_rsp_o,     // registered response
   input  logic [2:0]  dly_mask_i,   // limits the random ack delay
   input  logic        rty_en_i,     // allow random retries
   input  logic        err_en_i,     // answer err_adr_i with err
   input  logic [31:0] err_adr_i
);

   logic [63:0] mem [4096];   // 32 KB, word addressed, filled by the bench
   logic [15:0] lfsr;
   logic [2:0]  dly_bits;
   logic [1:0]  rty_bits;
   logic [2:0]  wait_cnt;     // cycles left before the answer
   logic        armed;        // delay drawn for the current request
   logic        busy_rsp;     // response on the bus this cycle
   logic [11:0] idx;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   assign busy_rsp = wb_rsp_o.ack | wb_rsp_o.rty | wb_rsp_o.err;
   assign idx      = wb_req_i.adr[14:3];

   always @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wb_rsp_o <= '0;
         lfsr     = 16'd13605;
         armed    <= 1'b0;
         wait_cnt <= 3'd0;
      end else begin
         wb_rsp_o.ack <= 1'b0;   // every answer lasts one cycle
         wb_rsp_o.rty <= 1'b0;
         wb_rsp_o.err <= 1'b0;
         if (!(wb_req_i.cyc && wb_req_i.stb) || busy_rsp) begin
            armed <= 1'b0;   // old request still seen right after an answer
         end else if (!armed) begin
            for (int i = 0; i < 3; i++) begin
               lfsr        = lfsr_step(lfsr);   // one step per bit
               dly_bits[i] = lfsr[0];
            end
            wait_cnt <= dly_bits & dly_mask_i;
            armed    <= 1'b1;
         end else if (wait_cnt != 3'd0) begin
            wait_cnt <= wait_cnt - 3'd1;
         end else begin
            armed          <= 1'b0;
            wb_rsp_o.dat   <= mem[idx][31:0];
            wb_rsp_o.dat64 <= mem[idx][63:32];
            rty_bits        = 2'b11;
            if (rty_en_i) begin
               for (int i = 0; i < 2; i++) begin
                  lfsr        = lfsr_step(lfsr);
                  rty_bits[i] = lfsr[0];
               end
            end
            if (err_en_i && wb_req_i.adr == err_adr_i) begin
               wb_rsp_o.err <= 1'b1;
            end else if (rty_bits == 2'b00) begin
               wb_rsp_o.rty <= 1'b1;   // about one beat in four
            end else begin
               wb_rsp_o.ack <= 1'b1;
            end
         end
      end
   end

endmodule

// ==== source/sg_dma_top.sv ====
`timescale 1ns/10ps
`include "sg_defines.svh"

module sg_dma_top
   import sg_pkg::*;
(
   input  logic        wb_clk_i,    // bus clock
   input  logic        wb_rst_i,    // async reset, active high
   input  logic        reg_we_i,    // host write strobe
   input  sg_reg_e     reg_adr_i,   // host register select
   input  logic [31:0] reg_dat_i,   // host write data
   output wb_req_t     wb_req_o,    // read master request
   input  wb_rsp_t     wb_rsp_i,    // memory response
   output sg_word_t    dat_o,       // stream head word
   output logic        valid_o,     // stream word present
   input  logic        pop_i,       // consumer pop
   output sg_status_t  status_o     // engine status
);

   sg_cmd_t  cmd;          // register block to reader
   logic     fifo_ready;   // fifo has room
   logic     push;         // acked buffer beat
   sg_word_t push_dat;

   sg_cmd_regs i_sg_cmd_regs (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .reg_we_i  (reg_we_i),
      .reg_adr_i (reg_adr_i),
      .reg_dat_i (reg_dat_i),
      .cmd_o     (cmd)
   );

   sg_reader i_sg_reader (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .cmd_i        (cmd),
      .wb_req_o     (wb_req_o),
      .wb_rsp_i     (wb_rsp_i),
      .fifo_ready_i (fifo_ready),
      .push_o       (push),
      .push_dat_o   (push_dat),
      .status_o     (status_o)
   );

   sg_fifo #(.AW(`SG_FIFO_AW)) i_sg_fifo (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .push_i     (push),
      .push_dat_i (push_dat),
      .ready_o    (fifo_ready),
      .dat_o      (dat_o),
      .valid_o    (valid_o),
      .pop_i      (pop_i)
   );

endmodule

// ==== source/sg_fifo.sv ====
`timescale 1ns/10ps
`include "sg_defines.svh"

module sg_fifo
   import sg_pkg::*;
#(
   parameter int AW = `SG_FIFO_AW   // log2 of depth
)(
   input  logic     wb_clk_i,     // bus clock
   input  logic     wb_rst_i,     // async reset, active high
   input  logic     push_i,       // write one word
   input  sg_word_t push_dat_i,   // word to write
   output logic     ready_o,      // room for a word
   output sg_word_t dat_o,        // head word, show-ahead
   output logic     valid_o,      // head word present
   input  logic     pop_i         // consumer takes the head
);

   localparam int DEPTH = 1 << AW;

   sg_word_t      mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;     // 0 to DEPTH
   logic          do_push;
   logic          do_pop;

   assign ready_o = !count[AW];   // msb only set when full
   assign valid_o = |count;
   assign dat_o   = mem[rd_ptr];

   assign do_push = push_i && ready_o;
   assign do_pop  = pop_i && valid_o;   // pop on empty ignored

   always_ff @(posedge wb_clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= push_dat_i;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of 2
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // reader must hold off while full
   a_no_overflow: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      push_i |-> ready_o);

endmodule

// ==== source/sg_reader.sv ====
`timescale 1ns/10ps
`include "sg_defines.svh"

module sg_reader
   import sg_pkg::*;
(
   input  logic       wb_clk_i,       // bus clock
   input  logic       wb_rst_i,       // async reset, active high
   input  sg_cmd_t    cmd_i,          // go, clear, first pointer
   output wb_req_t    wb_req_o,       // read request to memory
   input  wb_rsp_t    wb_rsp_i,       // data and handshake back
   input  logic       fifo_ready_i,   // fifo not full
   output logic       push_o,         // buffer word into fifo
   output sg_word_t   push_dat_o,     // word being pushed
   output sg_status_t status_o        // state, descriptor, error state
);

   sg_state_e state, state_n;
   sg_state_e err_state, err_state_n;
   wb_req_t   req, req_n;        // registered bus request
   sg_desc_t  desc, desc_n;      // current descriptor
   logic      cnt, cnt_n;        // descriptor beat, 1 = next pointer beat

   // fresh read request, one outstanding at a time
   function automatic wb_req_t rd_req(input logic [31:0] adr, input logic cab);
      wb_req_t r;
      r.cyc = 1'b1;
      r.stb = 1'b1;
      r.cab = cab;
      r.adr = adr;
      return r;
   endfunction

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state     <= S_IDLE;
         err_state <= S_IDLE;
         req       <= '0;
         cnt       <= 1'b0;
      end else begin
         state     <= state_n;
         err_state <= err_state_n;
         req       <= req_n;
         cnt       <= cnt_n;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      desc <= desc_n;   // reloaded on go before use
   end

   always_comb begin
      state_n     = state;
      err_state_n = err_state;
      req_n       = req;
      desc_n      = desc;
      cnt_n       = cnt;
      push_o      = 1'b0;

      case (state)
         S_IDLE: begin
            if (cmd_i.go) begin
               desc_n.next = cmd_i.first;
               desc_n.last = 1'b0;    // so S_NEXT fetches
               state_n     = S_NEXT;
            end
         end

         S_NEXT: begin
            if (desc.last) begin
               state_n = S_END;
            end else begin
               req_n   = rd_req({desc.next, 3'b000}, 1'b1);   // two beat burst
               cnt_n   = 1'b0;
               state_n = S_D_REQ;
            end
         end

         S_D_REQ: begin
            if (wb_rsp_i.err) begin
               err_state_n = state;
               req_n       = '0;
               state_n     = S_PANIC;
            end else if (wb_rsp_i.ack) begin
               if (!cnt) begin
                  desc_n.addr = wb_rsp_i.dat[31:3];
                  desc_n.len  = wb_rsp_i.dat64[`SG_LEN_W-1:0];
                  desc_n.last = wb_rsp_i.dat64[`SG_LAST_BIT];
                  req_n.adr   = req.adr + 32'd8;   // second beat
                  req_n.cab   = 1'b0;              // final beat
                  cnt_n       = 1'b1;
               end else begin
                  desc_n.next = wb_rsp_i.dat64[31:3];
                  req_n       = '0;
                  // empty buffer skips straight to the next pointer
                  state_n     = (desc.len == '0) ? S_NEXT : S_B_WAIT;
               end
            end
            // rty keeps the request as it is
         end

         S_B_WAIT: begin
            // cyc may stay high here between beats of one buffer
            if (fifo_ready_i) begin
               req_n   = rd_req({desc.addr, 3'b000}, desc.len != 1);
               state_n = S_B_REQ;
            end
         end

         S_B_REQ: begin
            if (wb_rsp_i.err) begin
               err_state_n = state;
               req_n       = '0;
               state_n     = S_PANIC;
            end else if (wb_rsp_i.rty) begin
               req_n   = '0;          // give up the bus, ask again
               state_n = S_B_WAIT;
            end else if (wb_rsp_i.ack) begin
               push_o      = 1'b1;
               desc_n.addr = desc.addr + 1'b1;
               desc_n.len  = desc.len - 1'b1;
               req_n.stb   = 1'b0;    // fifo level checked again first
               if (desc.len == 1) begin
                  req_n   = '0;
                  state_n = S_NEXT;
               end else begin
                  state_n = S_B_WAIT;
               end
            end
         end

         S_END, S_PANIC: begin
            if (cmd_i.clear) begin
               state_n = S_IDLE;
            end
         end

         default: begin
            req_n   = '0;
            state_n = S_IDLE;
         end
      endcase
   end

   assign wb_req_o   = req;
   assign push_dat_o = {wb_rsp_i.dat64, wb_rsp_i.dat};

   assign status_o.state     = state;
   assign status_o.desc      = desc;
   assign status_o.err_state = err_state;

   // strobe never outside a cycle
   a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wb_req_o.stb |-> wb_req_o.cyc);

   // a push is the acked beat at the current buffer address
   a_push_on_ack: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      push_o |-> state == S_B_REQ && wb_rsp_i.ack && wb_req_o.adr[31:3] == desc.addr);

   // bus released after an error
   a_panic_idle_bus: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      state == S_PANIC |-> !wb_req_o.cyc);

endmodule

// ==== source/sg_cmd_regs.sv ====
`timescale 1ns/10ps

module sg_cmd_regs
   import sg_pkg::*;
(
   input  logic        wb_clk_i,    // bus clock
   input  logic        wb_rst_i,    // async reset, active high
   input  logic        reg_we_i,    // host write strobe
   input  sg_reg_e     reg_adr_i,   // register select
   input  logic [31:0] reg_dat_i,   // host write data
   output sg_cmd_t     cmd_o        // to the reader
);

   logic        next_hit;    // write to pointer register
   logic        go_hit;      // write to go register
   logic        clear_hit;   // write to clear register
   logic        go_q;
   logic        clear_q;
   logic [31:3] first_q;     // first descriptor, 8 byte aligned

   // address decode, only on a write strobe
   always_comb begin
      next_hit  = 1'b0;
      go_hit    = 1'b0;
      clear_hit = 1'b0;
      if (reg_we_i) begin
         case (reg_adr_i)
            REG_CLEAR: clear_hit = 1'b1;
            REG_NEXT:  next_hit  = 1'b1;
            REG_GO:    go_hit    = 1'b1;
            REG_RSVD:  ;                   // write dropped
            default:   ;
         endcase
      end
   end

   // pulses last exactly one cycle after the write
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         go_q    <= 1'b0;
         clear_q <= 1'b0;
      end else begin
         go_q    <= go_hit;
         clear_q <= clear_hit;
      end
   end

   // pointer holds until the next write to it
   always_ff @(posedge wb_clk_i) begin
      if (next_hit) begin
         first_q <= reg_dat_i[31:3];   // low three bits dropped
      end
   end

   assign cmd_o.go    = go_q;
   assign cmd_o.clear = clear_q;
   assign cmd_o.first = first_q;

endmodule

// ==== source/sg_pkg.sv ====
`include "sg_defines.svh"

package sg_pkg;

   typedef enum logic [2:0] {
      S_IDLE   = 3'h0,   // waiting for go
      S_D_REQ  = 3'h2,   // descriptor fetch, two beats
      S_B_REQ  = 3'h3,   // buffer word on the bus
      S_B_WAIT = 3'h4,   // wait for fifo room
      S_NEXT   = 3'h5,   // follow next pointer or finish
      S_END    = 3'h6,   // chain done, wait for clear
      S_PANIC  = 3'h7    // bus error, wait for clear
   } sg_state_e;          // code 1 left free

   typedef enum logic [1:0] {
      REG_CLEAR = 2'd0,  // back to idle
      REG_RSVD  = 2'd1,  // no function
      REG_NEXT  = 2'd2,  // first descriptor pointer
      REG_GO    = 2'd3   // start the walk
   } sg_reg_e;

   typedef logic [63:0] sg_word_t;   // one bus beat

   typedef struct packed {
      logic                 last;   // final descriptor of the chain
      logic [`SG_LEN_W-1:0] len;    // words left in the buffer
      logic [31:3]          addr;   // next buffer word
      logic [31:3]          next;   // next descriptor
   } sg_desc_t;

   typedef struct packed {
      logic        go;      // one cycle start pulse
      logic        clear;   // one cycle clear pulse
      logic [31:3] first;   // first descriptor pointer
   } sg_cmd_t;

   typedef struct packed {
      sg_state_e state;
      sg_desc_t  desc;
      sg_state_e err_state;   // where the bus error came
   } sg_status_t;

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        cab;   // more beats of this burst follow
      logic [31:0] adr;
   } wb_req_t;

   typedef struct packed {
      logic [31:0] dat;     // low word
      logic [31:0] dat64;   // high word
      logic        ack;
      logic        rty;
      logic        err;
   } wb_rsp_t;

endpackage

// ==== include/sg_defines.svh ====
`ifndef SG_DEFINES_SVH
`define SG_DEFINES_SVH

// fifo depth as log2, 8 words by default
`define SG_FIFO_AW 3

// descriptor length field, counted in 64-bit words
`define SG_LEN_W 16

// last flag position in the descriptor high word
`define SG_LAST_BIT 20

`endif
